// ==== src/spuAdsr_defines.svh ====
`ifndef SPU_ADSR_DEFINES_SVH
`define SPU_ADSR_DEFINES_SVH

// Envelope level, unsigned 0..7FFFh
`define ADSR_LEVEL_W   15
`define ADSR_LEVEL_MAX 15'h7FFF

// Exponential increase slows down by 4 above this level
`define ADSR_EXP_KNEE  15'h6000

// Tick wait length, up to 2^20 times 4
`define ADSR_CYCLE_W   23

// Rate request fields
`define ADSR_SHIFT_W   5
`define ADSR_STEP_W    4

`endif

// ==== src/spuAdsrPkg.sv ====
package spuAdsrPkg;

	// ----------------------------------------------------------------------
	// Configuration word layout (i_adsrConfig)
	// ----------------------------------------------------------------------
	//   [31]    sustain exponential flag
	//   [30]    sustain direction, 0 increase / 1 decrease
	//   [29]    unused
	//   [28:24] sustain shift
	//   [23:22] sustain step
	//   [21]    release exponential flag
	//   [20:16] release shift
	//   [15]    attack exponential flag
	//   [14:10] attack shift
	//   [9:8]   attack step
	//   [7:4]   decay shift, scaled by 4 when used
	//   [3:0]   sustain level, threshold (n+1) * 800h

	// Envelope phase
	typedef enum logic [2:0] {
		OFF     = 3'd0,
		ATTACK  = 3'd1,
		DECAY   = 3'd2,
		SUSTAIN = 3'd3,
		RELEASE = 3'd4
	} adsrPhase_t;

	// Level direction for the current phase
	typedef enum logic {
		INCREASE = 1'b0,
		DECREASE = 1'b1
	} rateDir_t;

endpackage

// ==== src/adsrRateIf.sv ====
`timescale 1ns/1ps
`include "spuAdsr_defines.svh"

interface adsrRateIf;
	import spuAdsrPkg::*;

	// Request side, from the sequencer
	logic        [`ADSR_SHIFT_W-1:0] envShift;
	logic signed [`ADSR_STEP_W-1:0]  envStep;
	logic        [`ADSR_LEVEL_W-1:0] adsrLevel;
	rateDir_t                        rateDir;
	logic                            shift2ExpIncr;
	logic                            step2ExpDecr;

	// Result side, same cycle
	logic        [`ADSR_CYCLE_W-1:0] cycleCount;
	logic signed [`ADSR_LEVEL_W-1:0] adsrStep;

	modport seq (output envShift, envStep, adsrLevel, rateDir, shift2ExpIncr, step2ExpDecr,
		input cycleCount, adsrStep);

	modport calc (input envShift, envStep, adsrLevel, rateDir, shift2ExpIncr, step2ExpDecr,
		output cycleCount, adsrStep);

endinterface

// ==== src/adsrCycleCount.sv ====
`timescale 1ns/1ps
`include "spuAdsr_defines.svh"

module adsrCycleCount (
	adsrRateIf.calc io_rate
);
	import spuAdsrPkg::*;

	logic        [3:0]  shAmt;
	logic signed [4:0]  st1;
	logic signed [6:0]  st2;
	logic signed [10:0] st3;
	logic signed [18:0] st4;
	logic signed [`ADSR_LEVEL_W-1:0] stepLin;
	logic signed [29:0] stepProd;
	logic signed [29:0] stepBiased;
	logic signed [29:0] stepQuot;
	logic        [20:0] baseCount;
	logic               expDecr;
	logic               expIncr;

	// Mode flags only count for the matching direction
	assign expDecr = io_rate.step2ExpDecr && (io_rate.rateDir == DECREASE);
	assign expIncr = io_rate.shift2ExpIncr && (io_rate.rateDir == INCREASE);

	// ----------------------------------------------------------------------
	// Step computation
	// ----------------------------------------------------------------------

	// Left shift is 11 - shift, floored at 0
	always_comb begin
		if (io_rate.envShift > 5'd11) begin
			shAmt = 4'd0;
		end else begin
			shAmt = 4'd11 - io_rate.envShift[3:0];
		end
	end

	// Barrel shift in 1/2/4/8 stages, sign filled
	assign st1 = shAmt[0] ? {io_rate.envStep, 1'b0} : {io_rate.envStep[3], io_rate.envStep};
	assign st2 = shAmt[1] ? {st1, 2'b00} : {{2{st1[4]}}, st1};
	assign st3 = shAmt[2] ? {st2, 4'b0000} : {{4{st2[6]}}, st2};
	assign st4 = shAmt[3] ? {st3, 8'h00} : {{8{st3[10]}}, st3};

	// Max shift 11 on a 4-bit step fits 15 bits
	assign stepLin = st4[`ADSR_LEVEL_W-1:0];

	// Level scaled step, level as positive signed
	assign stepProd = stepLin * $signed({1'b0, io_rate.adsrLevel});

	// Divide by 8000h toward zero
	// Negative values get a bias of 7FFFh before the arithmetic shift
	assign stepBiased = stepProd + (stepProd[29] ? 30'sd32767 : 30'sd0);
	assign stepQuot   = stepBiased >>> 15;

	assign io_rate.adsrStep = expDecr ? stepQuot[`ADSR_LEVEL_W-1:0] : stepLin;

	// ----------------------------------------------------------------------
	// Wait length in ticks
	// ----------------------------------------------------------------------

	// 1 up to shift 11, then doubling per step
	always_comb begin
		if (io_rate.envShift <= 5'd11) begin
			baseCount = 21'd1;
		end else begin
			baseCount = 21'd1 << (io_rate.envShift - 5'd11);
		end
	end

	// Knee above 6000h waits four times longer
	assign io_rate.cycleCount = expIncr ? {baseCount, 2'b00} : {2'b00, baseCount};

endmodule

// ==== src/adsrSequencer.sv ====
`timescale 1ns/1ps
`include "spuAdsr_defines.svh"

module adsrSequencer (
	input  logic                      i_clk,
	input  logic                      i_arstN,
	input  logic                      i_keyOn,
	input  logic                      i_keyOff,
	input  logic                      i_sampleTick,
	input  logic [31:0]               i_adsrConfig,
	adsrRateIf.seq                    io_rate,
	output logic [`ADSR_LEVEL_W-1:0]  o_adsrLevel,
	output spuAdsrPkg::adsrPhase_t    o_phase
);
	import spuAdsrPkg::*;

	localparam logic [`ADSR_CYCLE_W-1:0] CNT_ONE = 1;

	// Configuration fields
	logic       attackExp;
	logic [4:0] attackShift;
	logic [1:0] attackStep;
	logic [3:0] decayShift;
	logic [3:0] sustainLevel;
	logic       sustainExp;
	logic       sustainDec;
	logic [4:0] sustainShift;
	logic [1:0] sustainStep;
	logic       releaseExp;
	logic [4:0] releaseShift;

	// State
	adsrPhase_t                phaseQ;
	adsrPhase_t                phaseNext;
	logic [`ADSR_CYCLE_W-1:0]  countQ;
	logic [`ADSR_LEVEL_W-1:0]  levelQ;

	// Rate request
	logic [5:0]                decayShiftX4;
	logic                      reqExp;
	rateDir_t                  reqDir;

	// Level update
	logic signed [16:0]        levelSum;
	logic [`ADSR_LEVEL_W-1:0]  levelNew;
	logic [4:0]                sustainUnits;
	logic [15:0]               sustainThresh;

	assign attackExp    = i_adsrConfig[15];
	assign attackShift  = i_adsrConfig[14:10];
	assign attackStep   = i_adsrConfig[9:8];
	assign decayShift   = i_adsrConfig[7:4];
	assign sustainLevel = i_adsrConfig[3:0];
	assign sustainExp   = i_adsrConfig[31];
	assign sustainDec   = i_adsrConfig[30];
	assign sustainShift = i_adsrConfig[28:24];
	assign sustainStep  = i_adsrConfig[23:22];
	assign releaseExp   = i_adsrConfig[21];
	assign releaseShift = i_adsrConfig[20:16];

	// ----------------------------------------------------------------------
	// Rate request per phase
	// ----------------------------------------------------------------------

	// Decay shift times 4, saturated to the 5-bit range
	assign decayShiftX4 = {decayShift, 2'b00};

	always_comb begin
		io_rate.envShift = 5'd0;
		io_rate.envStep  = 4'sd0;
		reqExp           = 1'b0;
		reqDir           = INCREASE;
		case (phaseQ)
			ATTACK: begin
				io_rate.envShift = attackShift;
				io_rate.envStep  = 4'sd7 - $signed({2'b00, attackStep});
				reqExp           = attackExp;
			end
			DECAY: begin
				io_rate.envShift = decayShiftX4[5] ? 5'd31 : decayShiftX4[4:0];
				io_rate.envStep  = -4'sd8;
				reqExp           = 1'b1;
				reqDir           = DECREASE;
			end
			SUSTAIN: begin
				io_rate.envShift = sustainShift;
				reqExp           = sustainExp;
				if (sustainDec) begin
					io_rate.envStep = -4'sd8 + $signed({2'b00, sustainStep});
					reqDir          = DECREASE;
				end else begin
					io_rate.envStep = 4'sd7 - $signed({2'b00, sustainStep});
				end
			end
			RELEASE: begin
				io_rate.envShift = releaseShift;
				io_rate.envStep  = -4'sd8;
				reqExp           = releaseExp;
				reqDir           = DECREASE;
			end
			default: begin
				// OFF requests nothing
				reqExp = 1'b0;
			end
		endcase
	end

	assign io_rate.rateDir       = reqDir;
	assign io_rate.adsrLevel     = levelQ;
	assign io_rate.shift2ExpIncr = reqExp && (reqDir == INCREASE) && (levelQ > `ADSR_EXP_KNEE);
	assign io_rate.step2ExpDecr  = reqExp && (reqDir == DECREASE);

	// ----------------------------------------------------------------------
	// Level update and phase transitions
	// ----------------------------------------------------------------------

	assign levelSum = $signed({2'b00, levelQ}) + io_rate.adsrStep;

	// Clamp to 0..7FFFh
	always_comb begin
		if (levelSum[16]) begin
			levelNew = '0;
		end else if (levelSum[15]) begin
			levelNew = `ADSR_LEVEL_MAX;
		end else begin
			levelNew = levelSum[`ADSR_LEVEL_W-1:0];
		end
	end

	// Sustain threshold (n+1) * 800h
	assign sustainUnits  = {1'b0, sustainLevel} + 5'd1;
	assign sustainThresh = {sustainUnits, 11'd0};

	always_comb begin
		phaseNext = phaseQ;
		case (phaseQ)
			ATTACK:  if (levelNew == `ADSR_LEVEL_MAX) phaseNext = DECAY;
			DECAY:   if ({1'b0, levelNew} <= sustainThresh) phaseNext = SUSTAIN;
			RELEASE: if (levelNew == '0) phaseNext = OFF;
			default: phaseNext = phaseQ;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			phaseQ <= OFF;
			countQ <= '0;
			levelQ <= '0;
		end else if (i_keyOn) begin
			// Key-on wins over key-off
			phaseQ <= ATTACK;
			countQ <= CNT_ONE;
			levelQ <= '0;
		end else if (i_keyOff && (phaseQ != OFF)) begin
			phaseQ <= RELEASE;
			countQ <= CNT_ONE;
		end else if (i_sampleTick) begin
			if (countQ > CNT_ONE) begin
				countQ <= countQ - CNT_ONE;
			end else if (phaseQ != OFF) begin
				// Reload from the pre-update level
				levelQ <= levelNew;
				countQ <= io_rate.cycleCount;
				phaseQ <= phaseNext;
			end
		end
	end

	assign o_adsrLevel = levelQ;
	assign o_phase     = phaseQ;

endmodule

// ==== src/spuAdsrVoice.sv ====
`timescale 1ns/1ps
`include "spuAdsr_defines.svh"

module spuAdsrVoice (
	input  logic                      i_clk,
	input  logic                      i_arstN,
	input  logic                      i_keyOn,
	input  logic                      i_keyOff,
	input  logic                      i_sampleTick,
	input  logic [31:0]               i_adsrConfig,
	output logic [`ADSR_LEVEL_W-1:0]  o_adsrLevel,
	output spuAdsrPkg::adsrPhase_t    o_phase
);

	// ----------------------------------------------------------------------
	// Rate request bus between sequencer and rate block
	// ----------------------------------------------------------------------
	adsrRateIf rateBus ();

	// Phase FSM, countdown and level register
	adsrSequencer uSequencer (
		.i_clk        (i_clk),
		.i_arstN      (i_arstN),
		.i_keyOn      (i_keyOn),
		.i_keyOff     (i_keyOff),
		.i_sampleTick (i_sampleTick),
		.i_adsrConfig (i_adsrConfig),
		.io_rate      (rateBus.seq),
		.o_adsrLevel  (o_adsrLevel),
		.o_phase      (o_phase)
	);

	// Zero latency step and wait length
	adsrCycleCount uCycleCount (
		.io_rate (rateBus.calc)
	);

endmodule

// ==== verif/spuAdsr_chk.sv ====
`timescale 1ns/1ps
`include "spuAdsr_defines.svh"

module spuAdsrChk (
	input logic                     i_clk,
	input logic                     i_arstN,
	input logic                     i_keyOn,
	input logic                     i_sampleTick,
	input logic [`ADSR_LEVEL_W-1:0] o_adsrLevel,
	input spuAdsrPkg::adsrPhase_t   o_phase
);
	import spuAdsrPkg::*;

	// Reset holds the FSM idle
	phaseOffInReset: assert property (@(posedge i_clk) !i_arstN |-> o_phase == OFF)
		else $error("phase not OFF during reset");

	keyOnStartsAttack: assert property (@(posedge i_clk) disable iff (!i_arstN)
		i_keyOn |=> (o_phase == ATTACK && o_adsrLevel == '0))
		else $error("key-on did not restart the attack");

	// Level moves only after a tick or key-on edge
	levelOnlyOnTick: assert property (@(posedge i_clk) disable iff (!i_arstN)
		(!$past(i_sampleTick) && !$past(i_keyOn)) |-> $stable(o_adsrLevel))
		else $error("level changed without a tick");

	offMeansSilent: assert property (@(posedge i_clk) disable iff (!i_arstN)
		o_phase == OFF |-> o_adsrLevel == '0)
		else $error("level not zero while OFF");

endmodule

bind spuAdsrVoice spuAdsrChk uChk (
	.i_clk        (i_clk),
	.i_arstN      (i_arstN),
	.i_keyOn      (i_keyOn),
	.i_sampleTick (i_sampleTick),
	.o_adsrLevel  (o_adsrLevel),
	.o_phase      (o_phase)
);

// ==== verif/tbSpuAdsr.sv ====
`timescale 1ns/1ps
`include "spuAdsr_defines.svh"

module tbSpuAdsr;
	import spuAdsrPkg::*;

	// Tick budget per run, used by the watchdog
	localparam longint ATTACK_LIMIT  = 600000;
	localparam longint DECAY_LIMIT   = 20000;
	localparam longint SUSTAIN_TICKS = 3000;
	localparam longint RELEASE_LIMIT = 100000;
	localparam longint PLAN_TICKS    = 2 * ATTACK_LIMIT + DECAY_LIMIT + 4 * SUSTAIN_TICKS
		+ 3 * (256 + RELEASE_LIMIT + 20) + 200;

	logic                     i_clk;
	logic                     i_arstN;
	logic                     i_keyOn;
	logic                     i_keyOff;
	logic                     i_sampleTick;
	logic [31:0]              i_adsrConfig;
	logic [`ADSR_LEVEL_W-1:0] o_adsrLevel;
	adsrPhase_t               o_phase;

	// Reference model state
	adsrPhase_t               mPhase;
	logic [`ADSR_LEVEL_W-1:0] mLevel;
	int                       mCount;
	logic [31:0]              cfg;
	logic [31:0]              lfsr;

	spuAdsrVoice DUT (
		.i_clk        (i_clk),
		.i_arstN      (i_arstN),
		.i_keyOn      (i_keyOn),
		.i_keyOff     (i_keyOff),
		.i_sampleTick (i_sampleTick),
		.i_adsrConfig (i_adsrConfig),
		.o_adsrLevel  (o_adsrLevel),
		.o_phase      (o_phase)
	);

	always #2 i_clk = ~i_clk;

	// ----------------------------------------------------------------------
	// Random source and failure reporting
	// ----------------------------------------------------------------------

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "run stopped");
	endtask

	task automatic checkLevel(input logic [`ADSR_LEVEL_W-1:0] got,
		input logic [`ADSR_LEVEL_W-1:0] expected);
		if (got !== expected) begin
			stopWithFailure($sformatf("ERR o_adsrLevel got %h expected %h", got, expected));
		end
	endtask

	task automatic checkPhase(input adsrPhase_t got, input adsrPhase_t expected);
		if (got !== expected) begin
			stopWithFailure($sformatf("ERR o_phase got %h expected %h", got, expected));
		end
	endtask

	// ----------------------------------------------------------------------
	// Reference model, one clock edge
	// ----------------------------------------------------------------------
	task automatic modelStep(input bit kOn, input bit kOff, input bit tk);
		int sh;
		int st;
		int stepVal;
		int waitLen;
		int sum;
		bit isExp;
		bit isDec;
		if (kOn) begin
			mPhase = ATTACK;
			mLevel = '0;
			mCount = 1;
		end else if (kOff && mPhase != OFF) begin
			mPhase = RELEASE;
			mCount = 1;
		end else if (tk && mCount > 1) begin
			mCount--;
		end else if (tk && mPhase != OFF) begin
			sh = 0;
			st = 0;
			isExp = 0;
			isDec = 0;
			case (mPhase)
				ATTACK: begin
					sh = int'(cfg[14:10]);
					st = 7 - int'(cfg[9:8]);
					isExp = cfg[15];
				end
				DECAY: begin
					sh = (int'(cfg[7:4]) * 4 > 31) ? 31 : int'(cfg[7:4]) * 4;
					st = -8;
					isExp = 1;
					isDec = 1;
				end
				SUSTAIN: begin
					sh = int'(cfg[28:24]);
					isExp = cfg[31];
					isDec = cfg[30];
					st = isDec ? (-8 + int'(cfg[23:22])) : (7 - int'(cfg[23:22]));
				end
				default: begin
					sh = int'(cfg[20:16]);
					st = -8;
					isExp = cfg[21];
					isDec = 1;
				end
			endcase
			stepVal = (sh > 11) ? st : st * (1 << (11 - sh));
			// Division truncates toward zero
			if (isExp && isDec) stepVal = (stepVal * int'(mLevel)) / 32768;
			waitLen = (sh <= 11) ? 1 : (1 << (sh - 11));
			if (isExp && !isDec && mLevel > `ADSR_EXP_KNEE) waitLen = waitLen * 4;
			sum = int'(mLevel) + stepVal;
			if (sum < 0) sum = 0;
			if (sum > 32767) sum = 32767;
			if (mPhase == ATTACK && sum == 32767) mPhase = DECAY;
			else if (mPhase == DECAY && sum <= (int'(cfg[3:0]) + 1) * 2048) mPhase = SUSTAIN;
			else if (mPhase == RELEASE && sum == 0) mPhase = OFF;
			mLevel = sum[`ADSR_LEVEL_W-1:0];
			mCount = waitLen;
		end
	endtask

	// Drive one cycle at edge plus 1 ns, then check after the next edge
	task automatic cycle(input bit kOn, input bit kOff, input bit tk);
		i_keyOn      = kOn;
		i_keyOff     = kOff;
		i_sampleTick = tk;
		i_adsrConfig = cfg;
		modelStep(kOn, kOff, tk);
		@(posedge i_clk);
		#1;
		checkLevel(o_adsrLevel, mLevel);
		checkPhase(o_phase, mPhase);
	endtask

	// One tick after 0 to 2 idle cycles
	task automatic doTick();
		logic [31:0] sp;
		sp = randBits(2);
		if (sp == 0) sp = 1;
		repeat (sp - 1) cycle(0, 0, 0);
		cycle(0, 0, 1);
	endtask

	task automatic runTicks(input longint n);
		for (longint i = 0; i < n; i++) doTick();
	endtask

	task automatic runUntil(input adsrPhase_t target, input longint limit);
		longint n;
		n = 0;
		while (mPhase != target) begin
			if (n >= limit) begin
				stopWithFailure($sformatf("Phase %s not reached within %0d ticks",
					target.name(), limit));
			end
			doTick();
			n++;
		end
	endtask

	// Shifts 0..15, decay field 0..2 so exponential decay reaches sustain
	function automatic logic [31:0] randConfig(input bit atkExp, input bit relExp);
		logic [31:0] c;
		logic [1:0]  d;
		c = '0;
		c[31]    = 1'(randBits(1));
		c[30]    = 1'(randBits(1));
		c[28:24] = 5'(randBits(4));
		c[23:22] = 2'(randBits(2));
		c[21]    = relExp;
		c[20:16] = 5'(randBits(4));
		c[15]    = atkExp;
		c[14:10] = 5'(randBits(4));
		c[9:8]   = 2'(randBits(2));
		d        = 2'(randBits(2));
		c[7:4]   = (d == 2'd3) ? 4'd2 : {2'b00, d};
		c[3:0]   = 4'(randBits(4));
		return c;
	endfunction

	// Watchdog
	initial begin
		#(PLAN_TICKS * 4 * 4 + 10000);
		stopWithFailure("Timeout, the run took longer than the planned tick budget");
	end

	initial begin
		lfsr         = 32'd86571;
		i_clk        = 1'b0;
		i_arstN      = 1'b0;
		i_keyOn      = 1'b0;
		i_keyOff     = 1'b0;
		i_sampleTick = 1'b0;
		i_adsrConfig = '0;
		cfg          = '0;
		mPhase       = OFF;
		mLevel       = '0;
		mCount       = 0;
		repeat (10) @(posedge i_clk);
		#1;
		i_arstN = 1'b1;
		checkPhase(o_phase, mPhase);

		// Linear then exponential attack, decay into sustain
		cfg = randConfig(1'b0, 1'b0);
		cycle(1, 0, 0);
		runUntil(DECAY, ATTACK_LIMIT);
		cfg = randConfig(1'b1, 1'b0);
		cycle(1, 0, 0);
		runUntil(DECAY, ATTACK_LIMIT);
		runUntil(SUSTAIN, DECAY_LIMIT);

		// Sustain in all direction and mode combinations, short shifts to hit clamps
		for (int m = 0; m < 4; m++) begin
			cfg[31]    = m[0];
			cfg[30]    = m[1];
			cfg[28:24] = 5'(randBits(3));
			runTicks(SUSTAIN_TICKS);
		end

		// Key-off from a random point, linear release to OFF
		for (int k = 0; k < 3; k++) begin
			cfg = randConfig(1'(randBits(1)), 1'b0);
			cycle(1, 0, 0);
			runTicks(randBits(8));
			cycle(0, 1, 0);
			runUntil(OFF, RELEASE_LIMIT);
			runTicks(20);
		end

		// Key-on during release, then key-on with key-off together
		cycle(1, 0, 0);
		runTicks(30);
		cycle(0, 1, 0);
		runTicks(10);
		cycle(1, 0, 0);
		runTicks(10);
		cycle(0, 1, 0);
		runTicks(5);
		cycle(1, 1, 0);
		runTicks(10);
		cycle(0, 0, 0);

		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+src
src/spuAdsrPkg.sv
src/adsrRateIf.sv
src/adsrCycleCount.sv
src/adsrSequencer.sv
src/spuAdsrVoice.sv
verif/spuAdsr_chk.sv
verif/tbSpuAdsr.sv

// ==== run.sh ====
#!/bin/sh
# Build and run with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tbSpuAdsr -f files.f -o simv \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| echo "=== FAIL ===" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0
